//--- common/controlPkg.sv
`default_nettype none

package controlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;
    typedef logic [31:0] wordT; // datapath word, PC adder width

    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opAndi  = 6'h0c;
    localparam opcodeT opXori  = 6'h0e;
    localparam opcodeT opLui   = 6'h0f;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    localparam functT fnNop   = 6'h00; // sll $0,$0,0
    localparam functT fnJr    = 6'h08;
    localparam functT fnBreak = 6'h0d;
    localparam functT fnAdd   = 6'h20;
    localparam functT fnAddu  = 6'h21;
    localparam functT fnSub   = 6'h22;
    localparam functT fnSubu  = 6'h23;
    localparam functT fnAnd   = 6'h24;
    localparam functT fnXor   = 6'h26;

    typedef enum logic [3:0] {
        clsArith, clsImm, clsLoad, clsStore, clsLui, clsJump,
        clsJumpReg, clsBranch, clsNop, clsBreak, clsIllegal
    } instrClassT;

    // encoding is fixed by the ALU
    typedef enum logic [2:0] {
        aluLoad, aluAdd, aluSub, aluAnd, aluInc, aluNeg, aluXor, aluComp
    } aluOpT;

    typedef enum logic [4:0] {
        fetch, fetchWait1, fetchWait2, decode,
        aritCalc, aritStore, immCalc, immStore,
        memAddr, memAddrWait1, memAddrWait2,
        memRead, memReadWait1, memReadWait2, memReadDone, memWrite,
        loadImm, jump, jumpReg, branch, halt,
        excpEpc, excpRead, excpWait1, excpWait2, excpTreat
    } ctrlStateT;

    typedef enum logic [1:0] {addrPc, addrAluOut, addrVector} addrSelT;
    typedef enum logic [1:0] {pcAlu, pcAluOut, pcJumpTarget, pcMemVector} pcSelT;
    typedef enum logic {aSelPc, aSelRegA} aluASelT;
    typedef enum logic [1:0] {bSelRegB, bSelFour, bSelImm, bSelImmShift} aluBSelT;
    typedef enum logic [1:0] {wbAluOut, wbMemData, wbUpperImm, wbPc} wbSelT;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;

    typedef enum logic {causeIllegal, causeOverflow} causeT;

    typedef struct packed {
        logic    pcWrite;
        logic    memWrite;
        logic    irWrite;
        logic    regWrite;
        logic    aWrite;
        logic    bWrite;
        logic    aluOutWrite;
        logic    mdrWrite;
        logic    epcWrite;
        logic    causeWrite;
        logic    treatSrc;  // handler vector select
        causeT   intCause;
        addrSelT addrSel;
        pcSelT   pcSel;
        aluASelT aluASel;
        aluBSelT aluBSel;
        wbSelT   wbSel;
        regDstT  regDst;
        aluOpT   aluOp;
    } controlWordT;

    typedef struct packed {
        logic  raise;
        causeT cause;
    } trapT;

endpackage

`default_nettype wire

//--- controlUnit/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::opcodeT      opcode,
    input  controlPkg::functT       funct,
    input  logic                    zero,
    input  logic                    overflow,
    input  logic                    causeLsb,  // bit 0 of the cause register
    output controlPkg::controlWordT ctrl,
    output controlPkg::ctrlStateT   stateOut
);

    controlPkg::instrClassT instrClass;
    controlPkg::aluOpT      aluOp;
    logic                   trapsOnOverflow;
    controlPkg::trapT       trap;

    instructionDecoder u_instructionDecoder (
        .opcode          (opcode),
        .funct           (funct),
        .instrClass      (instrClass),
        .aluOp           (aluOp),
        .trapsOnOverflow (trapsOnOverflow)
    );

    stateSequencer u_stateSequencer (
        .clock           (clock),
        .reset           (reset),
        .instrClass      (instrClass),
        .trapsOnOverflow (trapsOnOverflow),
        .overflow        (overflow),
        .state           (stateOut),
        .trap            (trap)
    );

    controlWordGen u_controlWordGen (
        .state      (stateOut),
        .instrClass (instrClass),
        .aluOp      (aluOp),
        .trap       (trap),
        .zero       (zero),
        .causeLsb   (causeLsb),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

//--- controlUnit/controlWordGen.sv
`timescale 1ns/1ns
`default_nettype none

module controlWordGen (
    input  controlPkg::ctrlStateT   state,
    input  controlPkg::instrClassT  instrClass,
    input  controlPkg::aluOpT       aluOp,
    input  controlPkg::trapT        trap,
    input  logic                    zero,
    input  logic                    causeLsb,
    output controlPkg::controlWordT ctrl
);

    logic link;
    logic branchTaken;

    assign link = instrClass == controlPkg::clsJump && aluOp == controlPkg::aluInc;

    // beq takes on zero, bne (aluComp) on not-zero
    assign branchTaken = instrClass == controlPkg::clsBranch
                         && ((aluOp == controlPkg::aluComp) ? !zero : zero);

    always_comb begin
        ctrl = '0;
        ctrl.causeWrite = trap.raise;
        ctrl.intCause   = trap.cause;

        case (state)
            controlPkg::fetch,
            controlPkg::fetchWait1,
            controlPkg::fetchWait2: begin
                ctrl.mdrWrite = 1'b1;
                ctrl.aluBSel  = controlPkg::bSelFour; // PC + 4
                if (state != controlPkg::fetch)
                    ctrl.aluOp = controlPkg::aluAdd;
                if (state == controlPkg::fetchWait2) begin
                    ctrl.pcWrite = 1'b1;
                    ctrl.irWrite = 1'b1;
                end
            end
            controlPkg::decode: begin
                ctrl.aWrite      = 1'b1;
                ctrl.bWrite      = 1'b1;
                ctrl.aluOutWrite = 1'b1; // branch target
                ctrl.aluBSel     = controlPkg::bSelImmShift;
                ctrl.aluOp       = controlPkg::aluAdd;
            end
            controlPkg::aritCalc,
            controlPkg::immCalc: begin
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluASel     = controlPkg::aSelRegA;
                ctrl.aluOp       = aluOp;
                if (state == controlPkg::immCalc)
                    ctrl.aluBSel = controlPkg::bSelImm;
            end
            controlPkg::aritStore: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = controlPkg::dstRd;
                ctrl.aluASel  = controlPkg::aSelRegA;
            end
            controlPkg::immStore: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluASel  = controlPkg::aSelRegA;
            end
            controlPkg::memAddr,
            controlPkg::memAddrWait1,
            controlPkg::memAddrWait2: begin
                ctrl.aluOutWrite = 1'b1;
                ctrl.aluASel     = controlPkg::aSelRegA;
                ctrl.aluBSel     = controlPkg::bSelImm;
                ctrl.aluOp       = controlPkg::aluAdd;
            end
            controlPkg::memRead,
            controlPkg::memReadWait1,
            controlPkg::memReadWait2,
            controlPkg::memReadDone: begin
                ctrl.mdrWrite = 1'b1;
                ctrl.addrSel  = controlPkg::addrAluOut;
                ctrl.aluASel  = controlPkg::aSelRegA;
                ctrl.aluOp    = controlPkg::aluAdd;
                ctrl.wbSel    = controlPkg::wbMemData;
                if (state == controlPkg::memReadDone)
                    ctrl.regWrite = 1'b1;
            end
            controlPkg::memWrite: begin
                ctrl.memWrite = 1'b1;
                ctrl.mdrWrite = 1'b1;
                ctrl.addrSel  = controlPkg::addrAluOut;
                ctrl.aluASel  = controlPkg::aSelRegA;
                ctrl.aluOp    = controlPkg::aluAdd;
            end
            controlPkg::loadImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = controlPkg::wbUpperImm;
            end
            controlPkg::jump: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSel   = controlPkg::pcJumpTarget;
                if (link) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.wbSel    = controlPkg::wbPc;
                    ctrl.regDst   = controlPkg::dstRa; // $31
                end
            end
            controlPkg::jumpReg: begin
                ctrl.pcWrite = 1'b1;
                ctrl.aluASel = controlPkg::aSelRegA; // A passes through the ALU
            end
            controlPkg::branch: begin
                ctrl.aluASel = controlPkg::aSelRegA;
                ctrl.aluOp   = controlPkg::aluSub; // compare sets zero
                if (branchTaken) begin
                    ctrl.pcWrite = 1'b1;
                    ctrl.pcSel   = controlPkg::pcAluOut;
                end
            end
            controlPkg::excpEpc: begin
                ctrl.epcWrite = 1'b1;
                ctrl.aluBSel  = controlPkg::bSelFour;
                ctrl.aluOp    = controlPkg::aluSub; // PC - 4
            end
            controlPkg::excpRead,
            controlPkg::excpWait1,
            controlPkg::excpWait2: ctrl.addrSel = controlPkg::addrVector;
            controlPkg::excpTreat: begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSel    = controlPkg::pcMemVector;
                ctrl.treatSrc = causeLsb;
            end
            default: ; // halt keeps everything inactive
        endcase

        // a store cycle must never also load the IR
        assert (!(ctrl.memWrite && ctrl.irWrite));
    end

endmodule

`default_nettype wire

//--- controlUnit/instructionDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instructionDecoder (
    input  controlPkg::opcodeT     opcode,
    input  controlPkg::functT      funct,
    output controlPkg::instrClassT instrClass,
    output controlPkg::aluOpT      aluOp,
    output logic                   trapsOnOverflow
);

    // aluOp doubles as a sub-flag for jump and branch:
    // aluInc marks jal, aluComp marks bne
    always_comb begin
        instrClass      = controlPkg::clsIllegal;
        aluOp           = controlPkg::aluLoad;
        trapsOnOverflow = 1'b0;

        case (opcode)
            controlPkg::opRtype: begin
                case (funct)
                    controlPkg::fnAdd: begin
                        instrClass      = controlPkg::clsArith;
                        aluOp           = controlPkg::aluAdd;
                        trapsOnOverflow = 1'b1;
                    end
                    controlPkg::fnAddu: begin
                        instrClass = controlPkg::clsArith;
                        aluOp      = controlPkg::aluAdd;
                    end
                    controlPkg::fnSub: begin
                        instrClass      = controlPkg::clsArith;
                        aluOp           = controlPkg::aluSub;
                        trapsOnOverflow = 1'b1;
                    end
                    controlPkg::fnSubu: begin
                        instrClass = controlPkg::clsArith;
                        aluOp      = controlPkg::aluSub;
                    end
                    controlPkg::fnAnd: begin
                        instrClass = controlPkg::clsArith;
                        aluOp      = controlPkg::aluAnd;
                    end
                    controlPkg::fnXor: begin
                        instrClass = controlPkg::clsArith;
                        aluOp      = controlPkg::aluXor;
                    end
                    controlPkg::fnJr:    instrClass = controlPkg::clsJumpReg;
                    controlPkg::fnBreak: instrClass = controlPkg::clsBreak;
                    controlPkg::fnNop:   instrClass = controlPkg::clsNop;
                    default:             instrClass = controlPkg::clsNop; // unknown funct
                endcase
            end
            controlPkg::opJ:   instrClass = controlPkg::clsJump;
            controlPkg::opJal: begin
                instrClass = controlPkg::clsJump;
                aluOp      = controlPkg::aluInc; // link
            end
            controlPkg::opBeq: begin
                instrClass = controlPkg::clsBranch;
                aluOp      = controlPkg::aluSub;
            end
            controlPkg::opBne: begin
                instrClass = controlPkg::clsBranch;
                aluOp      = controlPkg::aluComp; // inverted sense
            end
            controlPkg::opLw: begin
                instrClass = controlPkg::clsLoad;
                aluOp      = controlPkg::aluAdd;
            end
            controlPkg::opSw: begin
                instrClass = controlPkg::clsStore;
                aluOp      = controlPkg::aluAdd;
            end
            controlPkg::opLui: instrClass = controlPkg::clsLui;
            controlPkg::opAddi: begin
                instrClass      = controlPkg::clsImm;
                aluOp           = controlPkg::aluAdd;
                trapsOnOverflow = 1'b1;
            end
            controlPkg::opAddiu: begin
                instrClass = controlPkg::clsImm;
                aluOp      = controlPkg::aluAdd;
            end
            controlPkg::opAndi: begin
                instrClass = controlPkg::clsImm;
                aluOp      = controlPkg::aluAnd;
            end
            controlPkg::opXori: begin
                instrClass = controlPkg::clsImm;
                aluOp      = controlPkg::aluXor;
            end
            default: instrClass = controlPkg::clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

//--- controlUnit/stateSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module stateSequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  controlPkg::instrClassT instrClass,
    input  logic                   trapsOnOverflow,
    input  logic                   overflow,
    output controlPkg::ctrlStateT  state,
    output controlPkg::trapT       trap
);

    controlPkg::ctrlStateT nextState;

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            state <= controlPkg::fetch;
        else
            state <= nextState;
    end

    // trap decision, taken once here and shared with the control word
    always_comb begin
        trap = '0;
        if (state == controlPkg::decode && instrClass == controlPkg::clsIllegal) begin
            trap.raise = 1'b1;
            trap.cause = controlPkg::causeIllegal;
        end else if ((state == controlPkg::aritCalc || state == controlPkg::immCalc)
                     && trapsOnOverflow && overflow) begin
            trap.raise = 1'b1;
            trap.cause = controlPkg::causeOverflow;
        end
    end

    always_comb begin
        nextState = controlPkg::fetch;
        case (state)
            controlPkg::fetch:      nextState = controlPkg::fetchWait1;
            controlPkg::fetchWait1: nextState = controlPkg::fetchWait2;
            controlPkg::fetchWait2: nextState = controlPkg::decode;
            controlPkg::decode: begin
                case (instrClass)
                    controlPkg::clsArith:   nextState = controlPkg::aritCalc;
                    controlPkg::clsImm:     nextState = controlPkg::immCalc;
                    controlPkg::clsLoad,
                    controlPkg::clsStore:   nextState = controlPkg::memAddr;
                    controlPkg::clsLui:     nextState = controlPkg::loadImm;
                    controlPkg::clsJump:    nextState = controlPkg::jump;
                    controlPkg::clsJumpReg: nextState = controlPkg::jumpReg;
                    controlPkg::clsBranch:  nextState = controlPkg::branch;
                    controlPkg::clsNop,
                    controlPkg::clsBreak:   nextState = controlPkg::halt;
                    default:                nextState = controlPkg::excpEpc;
                endcase
            end
            controlPkg::aritCalc:     nextState = controlPkg::aritStore;
            controlPkg::immCalc:      nextState = controlPkg::immStore;
            controlPkg::memAddr:      nextState = controlPkg::memAddrWait1;
            controlPkg::memAddrWait1: nextState = controlPkg::memAddrWait2;
            controlPkg::memAddrWait2: begin
                if (instrClass == controlPkg::clsLoad)
                    nextState = controlPkg::memRead;
                else
                    nextState = controlPkg::memWrite;
            end
            controlPkg::memRead:      nextState = controlPkg::memReadWait1;
            controlPkg::memReadWait1: nextState = controlPkg::memReadWait2;
            controlPkg::memReadWait2: nextState = controlPkg::memReadDone;
            // nop spends one idle cycle here, break never leaves
            controlPkg::halt: begin
                if (instrClass == controlPkg::clsBreak)
                    nextState = controlPkg::halt;
                else
                    nextState = controlPkg::fetch;
            end
            controlPkg::excpEpc:   nextState = controlPkg::excpRead;
            controlPkg::excpRead:  nextState = controlPkg::excpWait1;
            controlPkg::excpWait1: nextState = controlPkg::excpWait2;
            controlPkg::excpWait2: nextState = controlPkg::excpTreat;
            default:               nextState = controlPkg::fetch; // single-cycle tails
        endcase

        if (trap.raise)
            nextState = controlPkg::excpEpc;
    end

    assert property (@(posedge clock) disable iff (reset)
        state == controlPkg::excpTreat |=> state == controlPkg::fetch);

    // raise only where the word generator drives causeWrite
    assert property (@(posedge clock) disable iff (reset)
        trap.raise |-> state inside {controlPkg::decode, controlPkg::aritCalc,
                                     controlPkg::immCalc});

    assert property (@(posedge clock) disable iff (reset)
        state == controlPkg::halt && instrClass == controlPkg::clsBreak
        |=> state == controlPkg::halt);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module controlUnitTb -f sources.f \
    -o controlUnitSim > build.log 2>&1 \
    && ./obj_dir/controlUnitSim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"
grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/controlModel.svh
`ifndef controlModelSvh
`define controlModelSvh

// reference behavior of the control unit, one instruction at a time

function automatic controlPkg::instrClassT classOf(input controlPkg::opcodeT op,
                                                   input controlPkg::functT fn);
    controlPkg::instrClassT r;
    case (op)
        controlPkg::opRtype: begin
            r = controlPkg::clsNop; // unknown funct runs as nop
            if (fn inside {controlPkg::fnAdd, controlPkg::fnAddu, controlPkg::fnSub,
                           controlPkg::fnSubu, controlPkg::fnAnd, controlPkg::fnXor})
                r = controlPkg::clsArith;
            else if (fn == controlPkg::fnJr)
                r = controlPkg::clsJumpReg;
            else if (fn == controlPkg::fnBreak)
                r = controlPkg::clsBreak;
        end
        controlPkg::opJ, controlPkg::opJal:     r = controlPkg::clsJump;
        controlPkg::opBeq, controlPkg::opBne:   r = controlPkg::clsBranch;
        controlPkg::opLw:                       r = controlPkg::clsLoad;
        controlPkg::opSw:                       r = controlPkg::clsStore;
        controlPkg::opLui:                      r = controlPkg::clsLui;
        controlPkg::opAddi, controlPkg::opAddiu,
        controlPkg::opAndi, controlPkg::opXori: r = controlPkg::clsImm;
        default:                                r = controlPkg::clsIllegal;
    endcase
    return r;
endfunction

// signed forms only
function automatic logic trapsOf(input controlPkg::opcodeT op, input controlPkg::functT fn);
    return op == controlPkg::opAddi || (op == controlPkg::opRtype
           && (fn == controlPkg::fnAdd || fn == controlPkg::fnSub));
endfunction

function automatic controlPkg::aluOpT aluOpOf(input controlPkg::opcodeT op,
                                              input controlPkg::functT fn);
    controlPkg::aluOpT r;
    logic rType;
    rType = op == controlPkg::opRtype;
    r = controlPkg::aluAdd;
    if (op == controlPkg::opAndi || (rType && fn == controlPkg::fnAnd))
        r = controlPkg::aluAnd;
    if (op == controlPkg::opXori || (rType && fn == controlPkg::fnXor))
        r = controlPkg::aluXor;
    if (rType && (fn == controlPkg::fnSub || fn == controlPkg::fnSubu))
        r = controlPkg::aluSub;
    return r;
endfunction

// state expected at a given cycle, counted from the entry into fetch
function automatic controlPkg::ctrlStateT stateAt(input controlPkg::instrClassT cls,
                                                  input logic trapOvf, input int step);
    controlPkg::ctrlStateT seq[$];
    controlPkg::ctrlStateT st;
    int count;
    seq = '{controlPkg::fetch, controlPkg::fetchWait1, controlPkg::fetchWait2,
            controlPkg::decode};
    st = controlPkg::excpEpc;
    count = 0;
    case (cls)
        controlPkg::clsArith:   seq.push_back(controlPkg::aritCalc);
        controlPkg::clsImm:     seq.push_back(controlPkg::immCalc);
        controlPkg::clsLoad: begin
            st = controlPkg::memAddr; // address, read and done run in order
            count = 7;
        end
        controlPkg::clsStore: begin
            st = controlPkg::memAddr;
            count = 3;
        end
        controlPkg::clsLui:     seq.push_back(controlPkg::loadImm);
        controlPkg::clsJump:    seq.push_back(controlPkg::jump);
        controlPkg::clsJumpReg: seq.push_back(controlPkg::jumpReg);
        controlPkg::clsBranch:  seq.push_back(controlPkg::branch);
        controlPkg::clsIllegal: count = 5;
        default:                seq.push_back(controlPkg::halt); // nop and break
    endcase
    if (trapOvf)
        count = 5;
    else if (cls == controlPkg::clsArith)
        seq.push_back(controlPkg::aritStore);
    else if (cls == controlPkg::clsImm)
        seq.push_back(controlPkg::immStore);
    repeat (count) begin
        seq.push_back(st);
        st = st.next();
    end
    if (cls == controlPkg::clsStore)
        seq.push_back(controlPkg::memWrite);
    if (step < seq.size())
        return seq[step];
    if (cls == controlPkg::clsBreak)
        return controlPkg::halt;
    return controlPkg::fetch;
endfunction

function automatic int lengthOf(input controlPkg::instrClassT cls, input logic trapOvf);
    int n;
    n = 1;
    while (n < 32 && stateAt(cls, trapOvf, n) != controlPkg::fetch)
        n++;
    return n;
endfunction

// {pcWrite, memWrite, irWrite, regWrite, epcWrite, causeWrite}
function automatic logic [5:0] writesAt(input controlPkg::ctrlStateT st, input logic link,
                                        input logic taken, input logic trapNow);
    logic pcW;
    logic regW;
    pcW = st inside {controlPkg::fetchWait2, controlPkg::jump, controlPkg::jumpReg,
                     controlPkg::excpTreat} || (st == controlPkg::branch && taken);
    regW = st inside {controlPkg::aritStore, controlPkg::immStore, controlPkg::memReadDone,
                      controlPkg::loadImm} || (st == controlPkg::jump && link);
    return {pcW, st == controlPkg::memWrite, st == controlPkg::fetchWait2, regW,
            st == controlPkg::excpEpc, trapNow};
endfunction

`endif

//--- sim/controlUnitTb.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

    `include "controlModel.svh"

    localparam int waitLimit = 40; // cycles per wait

    logic clock;
    logic reset;
    controlPkg::opcodeT opcode;
    controlPkg::functT funct;
    logic zero;
    logic overflow;
    logic causeLsb;
    controlPkg::controlWordT ctrl;
    controlPkg::ctrlStateT stateOut;

    controlPkg::opcodeT poolOp[$];
    controlPkg::functT poolFn[$];
    controlPkg::instrClassT curCls;
    logic curTrap; // overflow trap expected
    string testName;
    int step;
    bit active;
    int errorCount;
    int checkCount;

    controlUnit u_controlUnit (
        .clock    (clock),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .zero     (zero),
        .overflow (overflow),
        .causeLsb (causeLsb),
        .ctrl     (ctrl),
        .stateOut (stateOut)
    );

    always #20 clock = ~clock;

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[ERROR] %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    task automatic waitForState(input controlPkg::ctrlStateT target, output int cycles);
        cycles = 0;
        do begin
            @(posedge clock);
            #2;
            cycles++;
        end while (stateOut != target && cycles < waitLimit);
        if (stateOut != target) begin
            errorCount++;
            $display("%s never reached state %s within %0d cycles", testName, target.name(),
                     waitLimit);
            $display("checks %0d, errors %0d", checkCount, errorCount);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    endtask

    task automatic compareCycle();
        controlPkg::ctrlStateT expState;
        logic trapNow;
        logic taken;
        logic link;
        expState = stateAt(curCls, curTrap, step);
        trapNow = (expState == controlPkg::decode && curCls == controlPkg::clsIllegal)
                  || (expState inside {controlPkg::aritCalc, controlPkg::immCalc} && curTrap);
        taken = (opcode == controlPkg::opBeq) ? zero : !zero;
        link = opcode == controlPkg::opJal;
        check({testName, " state"}, 32'(expState), 32'(stateOut));
        check({testName, " writes"}, 32'(writesAt(expState, link, taken, trapNow)),
              32'({ctrl.pcWrite, ctrl.memWrite, ctrl.irWrite, ctrl.regWrite, ctrl.epcWrite,
                   ctrl.causeWrite}));
        if (trapNow)
            check({testName, " intCause"}, 32'(curCls == controlPkg::clsIllegal ?
                  controlPkg::causeIllegal : controlPkg::causeOverflow), 32'(ctrl.intCause));
        case (expState)
            controlPkg::aritCalc,
            controlPkg::immCalc:
                check({testName, " aluOp"}, 32'(aluOpOf(opcode, funct)), 32'(ctrl.aluOp));
            controlPkg::aritStore:
                check({testName, " regDst"}, 32'(controlPkg::dstRd), 32'(ctrl.regDst));
            controlPkg::immStore:
                check({testName, " regDst"}, 32'(controlPkg::dstRt), 32'(ctrl.regDst));
            controlPkg::memReadDone:
                check({testName, " wbSel"}, 32'(controlPkg::wbMemData), 32'(ctrl.wbSel));
            controlPkg::jump: begin
                check({testName, " pcSel"}, 32'(controlPkg::pcJumpTarget), 32'(ctrl.pcSel));
                if (link) begin
                    check({testName, " regDst"}, 32'(controlPkg::dstRa), 32'(ctrl.regDst));
                    check({testName, " wbSel"}, 32'(controlPkg::wbPc), 32'(ctrl.wbSel));
                end
            end
            controlPkg::branch: begin
                if (taken) // target waits in the ALU register since decode
                    check({testName, " pcSel"}, 32'(controlPkg::pcAluOut), 32'(ctrl.pcSel));
            end
            controlPkg::excpTreat: begin
                check({testName, " treatSrc"}, 32'(causeLsb), 32'(ctrl.treatSrc));
                check({testName, " pcSel"}, 32'(controlPkg::pcMemVector), 32'(ctrl.pcSel));
            end
            controlPkg::halt:
                check({testName, " idle writes"}, 32'd0, 32'({ctrl.aWrite, ctrl.bWrite,
                      ctrl.aluOutWrite, ctrl.mdrWrite}));
            default: ;
        endcase
        step++;
    endtask

    // applies an instruction, the comparing process restarts at fetch
    task automatic loadInstr(input controlPkg::opcodeT op, input controlPkg::functT fn,
                             input logic ovf, input logic z, input logic cl);
        opcode = op;
        funct = fn;
        overflow = ovf;
        zero = z;
        causeLsb = cl;
        curCls = classOf(op, fn);
        curTrap = ovf && trapsOf(op, fn);
        testName = $sformatf("op %02h fn %02h ovf %0b zero %0b", op, fn, ovf, z);
        step = 0;
        active = 1'b1;
    endtask

    // starts in fetch, returns once the next fetch is entered
    task automatic runInstr(input controlPkg::opcodeT op, input controlPkg::functT fn,
                            input logic ovf, input logic z, input logic cl);
        int cycles;
        loadInstr(op, fn, ovf, z, cl);
        waitForState(controlPkg::fetch, cycles);
        check({testName, " cycles"}, 32'(lengthOf(curCls, curTrap)), 32'(cycles));
    endtask

    always @(negedge clock) begin
        if (active)
            compareCycle();
    end

    initial begin
        int k;
        int cycles;
        controlPkg::functT fn;
        void'($urandom(44));
        clock = 1'b0;
        reset = 1'b1;
        opcode = controlPkg::opRtype;
        funct = controlPkg::fnNop;
        zero = 1'b0;
        overflow = 1'b0;
        causeLsb = 1'b0;
        active = 1'b0;
        step = 0;
        errorCount = 0;
        checkCount = 0;
        testName = "reset";
        repeat (9) poolOp.push_back(controlPkg::opRtype);
        poolFn = '{controlPkg::fnAdd, controlPkg::fnAddu, controlPkg::fnSub, controlPkg::fnSubu,
                   controlPkg::fnAnd, controlPkg::fnXor, controlPkg::fnJr, controlPkg::fnNop,
                   6'h02}; // srl was dropped, runs as nop
        poolOp = {poolOp, controlPkg::opAddi, controlPkg::opAddiu, controlPkg::opAndi,
                  controlPkg::opXori, controlPkg::opLw, controlPkg::opSw, controlPkg::opLui,
                  controlPkg::opJ, controlPkg::opJal, controlPkg::opBeq, controlPkg::opBne,
                  6'h3f}; // last one is not decoded
        repeat (12) poolFn.push_back(6'h00);

        repeat (5) @(posedge clock);
        #2;
        check("reset state", 32'(controlPkg::fetch), 32'(stateOut));
        check("reset writes", 32'd0, 32'({ctrl.pcWrite, ctrl.irWrite, ctrl.regWrite,
              ctrl.memWrite}));
        reset = 1'b0;

        for (k = 0; k < poolOp.size(); k++) begin
            runInstr(poolOp[k], poolFn[k], 1'b0, 1'b0, k[0]);
            runInstr(poolOp[k], poolFn[k], 1'b1, 1'b1, ~k[0]);
        end
        repeat (40) begin
            k = int'($urandom % poolOp.size());
            fn = (poolOp[k] == controlPkg::opRtype) ? poolFn[k] : 6'($urandom);
            runInstr(poolOp[k], fn, 1'($urandom), 1'($urandom), 1'($urandom));
        end

        // break holds in halt until the next reset
        loadInstr(controlPkg::opRtype, controlPkg::fnBreak, 1'b0, 1'b0, 1'b0);
        testName = "break";
        waitForState(controlPkg::halt, cycles);
        check("break cycles to halt", 32'd4, 32'(cycles));
        repeat (20) @(posedge clock);
        #2;
        active = 1'b0;
        reset = 1'b1;
        @(negedge clock);
        check("break reset state", 32'(controlPkg::fetch), 32'(stateOut));
        @(posedge clock);
        #2;
        reset = 1'b0;
        runInstr(controlPkg::opRtype, controlPkg::fnNop, 1'b0, 1'b0, 1'b0);

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+sim
common/controlPkg.sv
controlUnit/instructionDecoder.sv
controlUnit/stateSequencer.sv
controlUnit/controlWordGen.sv
controlUnit/controlUnit.sv
sim/controlUnitTb.sv
